// ==== rtl/riscv_defines.sv ====
package riscv_defines;

	//////////////////////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////////////////////

	// Data path and byte address width
	localparam int WORD_WIDTH     = 32;
	// Register index
	localparam int REG_ADDR_WIDTH = 5;
	// Data memory word index, 256 words
	localparam int RAM_ADDR_WIDTH = 8;

	//////////////////////////////////////////////////////////////////////////////
	// Decoded load and store types from execute
	//////////////////////////////////////////////////////////////////////////////

	// Bit 2 set with a sub-word size means unsigned
	localparam logic [2:0] LOAD_NONE = 3'b000;
	localparam logic [2:0] LOAD_LB   = 3'b001;
	localparam logic [2:0] LOAD_LH   = 3'b010;
	localparam logic [2:0] LOAD_LW   = 3'b100;
	localparam logic [2:0] LOAD_LBU  = 3'b101;
	localparam logic [2:0] LOAD_LHU  = 3'b110;

	// Store width
	localparam logic [1:0] STORE_NONE = 2'b00;
	localparam logic [1:0] STORE_SB   = 2'b01;
	localparam logic [1:0] STORE_SH   = 2'b10;
	localparam logic [1:0] STORE_SW   = 2'b11;

	//////////////////////////////////////////////////////////////////////////////
	// Access size seen by the LSU
	//////////////////////////////////////////////////////////////////////////////

	// Same code for loads and stores
	localparam logic [1:0] LSU_NONE = 2'b00;
	localparam logic [1:0] LSU_BYTE = 2'b01;
	localparam logic [1:0] LSU_HALF = 2'b10;
	localparam logic [1:0] LSU_WORD = 2'b11;

	//////////////////////////////////////////////////////////////////////////////
	// Memory word views
	//////////////////////////////////////////////////////////////////////////////

	// Byte lane 0 is the least significant byte
	// Halfword 1 sits on lanes 3 and 2
	typedef union packed {
		logic [3:0][7:0]  b;
		logic [1:0][15:0] h;
	} mem_word_u;

endpackage

// ==== rtl/lsu_lite.sv ====
`timescale 1ns/100ps

module lsu_lite (
	input  logic                                 clk,
	input  logic                                 rst_i,

	// Request from the writeback stage
	input  logic                                 start_i,
	input  logic [1:0]                           size_i,
	input  logic                                 write_i,
	input  logic [riscv_defines::WORD_WIDTH-1:0] addr_i,
	input  logic [riscv_defines::WORD_WIDTH-1:0] wdata_i,

	// Data memory side
	output logic                                 data_req_o,
	output logic [riscv_defines::WORD_WIDTH-1:0] data_addr_o,
	output logic                                 data_we_o,
	output logic [3:0]                           data_be_o,
	output logic [riscv_defines::WORD_WIDTH-1:0] data_wdata_o,
	input  logic                                 data_gnt_i,
	input  logic                                 data_rvalid_i,
	input  logic [riscv_defines::WORD_WIDTH-1:0] data_rdata_i,

	// Load return toward the stage
	output logic [riscv_defines::WORD_WIDTH-1:0] rdata_o,
	output logic                                 rdata_valid_o,
	output logic [1:0]                           lane_o,
	output logic                                 busy_o
);

	import riscv_defines::*;

	// Request fields formed from the stage inputs
	logic [3:0]            be_next;
	mem_word_u             wdata_lanes;

	// Transaction state
	logic                  req_q;
	logic                  rd_wait_q;

	// Held request fields
	logic                  we_q;
	logic [3:0]            be_q;
	logic [WORD_WIDTH-1:0] addr_q;
	logic [WORD_WIDTH-1:0] wdata_q;
	logic [1:0]            lane_q;

	//////////////////////////////////////////////////////////////////////////////
	// Request formatting
	//////////////////////////////////////////////////////////////////////////////

	// Byte enables from size and low address bits
	// Address bits below the access size are dropped
	always_comb begin
		case (size_i)
			LSU_BYTE: be_next = 4'b0001 << addr_i[1:0];
			LSU_HALF: be_next = addr_i[1] ? 4'b1100 : 4'b0011;
			LSU_WORD: be_next = 4'b1111;
			default:  be_next = 4'b0000;
		endcase
	end

	// Copy the store data into every lane of its size
	// Memory picks the right lane through the byte enables
	always_comb begin
		case (size_i)
			LSU_BYTE: begin
				for (int i = 0; i < 4; i++) begin
					wdata_lanes.b[i] = wdata_i[7:0];
				end
			end
			LSU_HALF: begin
				wdata_lanes.h[0] = wdata_i[15:0];
				wdata_lanes.h[1] = wdata_i[15:0];
			end
			default: begin
				// Full word goes out unchanged
				wdata_lanes = mem_word_u'(wdata_i);
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////////////
	// Transaction tracking
	//////////////////////////////////////////////////////////////////////////////

	// Request rises the cycle after start and drops after the grant cycle
	// Reads then wait for the data beat
	always_ff @(posedge clk) begin
		if (rst_i) begin
			req_q     <= 1'b0;
			rd_wait_q <= 1'b0;
		end else begin
			if (start_i) begin
				req_q <= 1'b1;
			end else if (req_q && data_gnt_i) begin
				req_q <= 1'b0;
			end

			if (req_q && data_gnt_i && !we_q) begin
				rd_wait_q <= 1'b1;
			end else if (rd_wait_q && data_rvalid_i) begin
				rd_wait_q <= 1'b0;
			end
		end
	end

	// Fields stay constant until grant
	always_ff @(posedge clk) begin
		if (start_i) begin
			we_q    <= write_i;
			be_q    <= be_next;
			addr_q  <= {addr_i[WORD_WIDTH-1:2], 2'b00};
			wdata_q <= wdata_lanes;
			lane_q  <= addr_i[1:0];
		end
	end

	// Bus outputs
	assign data_req_o   = req_q;
	assign data_addr_o  = addr_q;
	assign data_we_o    = we_q;
	assign data_be_o    = be_q;
	assign data_wdata_o = wdata_q;

	// Raw word and lane go to the stage for extraction
	assign rdata_o       = data_rdata_i;
	assign rdata_valid_o = rd_wait_q & data_rvalid_i;
	assign lane_o        = lane_q;

	// High across grant wait and read return
	assign busy_o = req_q | rd_wait_q;

endmodule

// ==== rtl/wb_stage.sv ====
`timescale 1ns/100ps

module wb_stage (
	input  logic                                     clk,
	input  logic                                     rst_i,

	// From execute
	input  logic                                     valid_i,
	input  logic [riscv_defines::WORD_WIDTH-1:0]     alu_result_i,
	input  logic [riscv_defines::WORD_WIDTH-1:0]     store_data_i,
	input  logic [riscv_defines::REG_ADDR_WIDTH-1:0] rd_i,
	input  logic [2:0]                               load_type_i,
	input  logic [1:0]                               store_type_i,

	// Register file write port
	output logic                                     reg_we_o,
	output logic [riscv_defines::REG_ADDR_WIDTH-1:0] reg_waddr_o,
	output logic [riscv_defines::WORD_WIDTH-1:0]     reg_wdata_o,
	output logic                                     busy_o,

	// Data memory bus
	output logic                                     data_req_o,
	output logic [riscv_defines::WORD_WIDTH-1:0]     data_addr_o,
	output logic                                     data_we_o,
	output logic [3:0]                               data_be_o,
	output logic [riscv_defines::WORD_WIDTH-1:0]     data_wdata_o,
	input  logic                                     data_gnt_i,
	input  logic                                     data_rvalid_i,
	input  logic [riscv_defines::WORD_WIDTH-1:0]     data_rdata_i
);

	import riscv_defines::*;

	// Instruction class
	logic                      load_flag;
	logic                      store_flag;
	logic                      alu_valid;

	// LSU control and return
	logic [1:0]                lsu_size;
	logic                      lsu_start;
	logic                      lsu_write;
	logic [WORD_WIDTH-1:0]     lsu_rdata;
	logic                      lsu_rdata_valid;
	logic [1:0]                lsu_lane;
	logic                      lsu_busy;

	// Load data path
	mem_word_u                 rdata_lanes;
	logic [7:0]                load_byte;
	logic [15:0]               load_half;
	logic [WORD_WIDTH-1:0]     load_ext;

	// Registered state
	logic                      load_pending_q;
	logic [2:0]                load_type_q;
	logic [REG_ADDR_WIDTH-1:0] rd_q;
	logic                      reg_we_q;
	logic [WORD_WIDTH-1:0]     reg_wdata_q;

	// Loads take priority if both codes are set
	assign load_flag  = (load_type_i != LOAD_NONE);
	assign store_flag = (store_type_i != STORE_NONE);
	assign alu_valid  = valid_i & ~load_flag & ~store_flag;
	assign lsu_start  = valid_i & (load_flag | store_flag);
	assign lsu_write  = store_flag & ~load_flag;

	// Decoded type to LSU access size
	always_comb begin
		if (load_flag) begin
			case (load_type_i)
				LOAD_LB, LOAD_LBU: lsu_size = LSU_BYTE;
				LOAD_LH, LOAD_LHU: lsu_size = LSU_HALF;
				LOAD_LW:           lsu_size = LSU_WORD;
				default:           lsu_size = LSU_NONE;
			endcase
		end else begin
			case (store_type_i)
				STORE_SB: lsu_size = LSU_BYTE;
				STORE_SH: lsu_size = LSU_HALF;
				STORE_SW: lsu_size = LSU_WORD;
				default:  lsu_size = LSU_NONE;
			endcase
		end
	end

	lsu_lite u_lsu (
		.clk           (clk),
		.rst_i         (rst_i),
		.start_i       (lsu_start),
		.size_i        (lsu_size),
		.write_i       (lsu_write),
		.addr_i        (alu_result_i),
		.wdata_i       (store_data_i),
		.data_req_o    (data_req_o),
		.data_addr_o   (data_addr_o),
		.data_we_o     (data_we_o),
		.data_be_o     (data_be_o),
		.data_wdata_o  (data_wdata_o),
		.data_gnt_i    (data_gnt_i),
		.data_rvalid_i (data_rvalid_i),
		.data_rdata_i  (data_rdata_i),
		.rdata_o       (lsu_rdata),
		.rdata_valid_o (lsu_rdata_valid),
		.lane_o        (lsu_lane),
		.busy_o        (lsu_busy)
	);

	//////////////////////////////////////////////////////////////////////////////
	// Load alignment and extension
	//////////////////////////////////////////////////////////////////////////////

	// Pick the addressed byte or halfword from the raw word
	assign rdata_lanes = mem_word_u'(lsu_rdata);
	assign load_byte   = rdata_lanes.b[lsu_lane];
	assign load_half   = rdata_lanes.h[lsu_lane[1]];

	// Signed loads fill with copies of the sign bit
	always_comb begin
		case (load_type_q)
			LOAD_LB:  load_ext = {{(WORD_WIDTH-8){load_byte[7]}}, load_byte};
			LOAD_LBU: load_ext = {{(WORD_WIDTH-8){1'b0}}, load_byte};
			LOAD_LH:  load_ext = {{(WORD_WIDTH-16){load_half[15]}}, load_half};
			LOAD_LHU: load_ext = {{(WORD_WIDTH-16){1'b0}}, load_half};
			default:  load_ext = lsu_rdata;
		endcase
	end

	//////////////////////////////////////////////////////////////////////////////
	// Register write sequencing
	//////////////////////////////////////////////////////////////////////////////

	// ALU writes one cycle after valid, loads one cycle after the data beat
	always_ff @(posedge clk) begin
		if (rst_i) begin
			reg_we_q       <= 1'b0;
			load_pending_q <= 1'b0;
		end else begin
			reg_we_q <= alu_valid | (load_pending_q & lsu_rdata_valid);
			if (valid_i && load_flag) begin
				load_pending_q <= 1'b1;
			end else if (lsu_rdata_valid) begin
				load_pending_q <= 1'b0;
			end
		end
	end

	// Destination, load type and write value
	always_ff @(posedge clk) begin
		if (valid_i) begin
			rd_q <= rd_i;
		end
		if (valid_i && load_flag) begin
			load_type_q <= load_type_i;
		end
		if (alu_valid) begin
			reg_wdata_q <= alu_result_i;
		end else if (load_pending_q && lsu_rdata_valid) begin
			reg_wdata_q <= load_ext;
		end
	end

	assign reg_we_o    = reg_we_q;
	assign reg_waddr_o = rd_q;
	assign reg_wdata_o = reg_wdata_q;

	// Stall upstream until the memory side is done
	assign busy_o = lsu_busy | load_pending_q;

endmodule

// ==== rtl/data_ram.sv ====
`timescale 1ns/100ps

module data_ram #(
	parameter int WAIT_STATES = 2
) (
	input  logic                                 clk,
	input  logic                                 rst_i,

	// Request side
	input  logic                                 data_req_i,
	input  logic [riscv_defines::WORD_WIDTH-1:0] data_addr_i,
	input  logic                                 data_we_i,
	input  logic [3:0]                           data_be_i,
	input  logic [riscv_defines::WORD_WIDTH-1:0] data_wdata_i,

	// Response side
	output logic                                 data_gnt_o,
	output logic                                 data_rvalid_o,
	output logic [riscv_defines::WORD_WIDTH-1:0] data_rdata_o
);

	import riscv_defines::*;

	// Storage, zero at start
	logic [WORD_WIDTH-1:0]     mem [0:(1 << RAM_ADDR_WIDTH)-1] = '{default: '0};

	// Grant wait, 0 to 3 cycles
	logic [1:0]                wait_cnt_q;
	logic                      gnt;

	// Word index, upper address bits are ignored
	logic [RAM_ADDR_WIDTH-1:0] word_idx;

	// Read return
	logic                      rvalid_q;
	logic [WORD_WIDTH-1:0]     rdata_q;

	assign word_idx = data_addr_i[RAM_ADDR_WIDTH+1:2];

	//////////////////////////////////////////////////////////////////////////////
	// Grant timing
	//////////////////////////////////////////////////////////////////////////////

	// Counts cycles the current request has waited
	assign gnt = data_req_i & (wait_cnt_q == 2'(WAIT_STATES));

	always_ff @(posedge clk) begin
		if (rst_i) begin
			wait_cnt_q <= '0;
		end else if (gnt) begin
			wait_cnt_q <= '0;
		end else if (data_req_i) begin
			wait_cnt_q <= wait_cnt_q + 2'd1;
		end
	end

	//////////////////////////////////////////////////////////////////////////////
	// Array access
	//////////////////////////////////////////////////////////////////////////////

	// Write lands in the grant cycle, enabled bytes only
	always_ff @(posedge clk) begin
		if (gnt && data_we_i) begin
			for (int i = 0; i < 4; i++) begin
				if (data_be_i[i]) begin
					mem[word_idx][8*i +: 8] <= data_wdata_i[8*i +: 8];
				end
			end
		end
	end

	// Read data one cycle after grant
	always_ff @(posedge clk) begin
		if (gnt && !data_we_i) begin
			rdata_q <= mem[word_idx];
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			rvalid_q <= 1'b0;
		end else begin
			rvalid_q <= gnt & ~data_we_i;
		end
	end

	assign data_gnt_o    = gnt;
	assign data_rvalid_o = rvalid_q;
	assign data_rdata_o  = rdata_q;

endmodule

// ==== rtl/wb_subsystem.sv ====
`timescale 1ns/100ps

module wb_subsystem #(
	parameter int WAIT_STATES = 2
) (
	input  logic                                     clk,
	input  logic                                     rst_i,

	// Execute side
	input  logic                                     valid_i,
	input  logic [riscv_defines::WORD_WIDTH-1:0]     alu_result_i,
	input  logic [riscv_defines::WORD_WIDTH-1:0]     store_data_i,
	input  logic [riscv_defines::REG_ADDR_WIDTH-1:0] rd_i,
	input  logic [2:0]                               load_type_i,
	input  logic [1:0]                               store_type_i,

	// Register file write port
	output logic                                     reg_we_o,
	output logic [riscv_defines::REG_ADDR_WIDTH-1:0] reg_waddr_o,
	output logic [riscv_defines::WORD_WIDTH-1:0]     reg_wdata_o,

	// Upstream stall
	output logic                                     busy_o
);

	import riscv_defines::*;

	// Memory bus between stage and RAM
	logic                  data_req;
	logic [WORD_WIDTH-1:0] data_addr;
	logic                  data_we;
	logic [3:0]            data_be;
	logic [WORD_WIDTH-1:0] data_wdata;
	logic                  data_gnt;
	logic                  data_rvalid;
	logic [WORD_WIDTH-1:0] data_rdata;

	wb_stage u_wb_stage (
		.clk           (clk),
		.rst_i         (rst_i),
		.valid_i       (valid_i),
		.alu_result_i  (alu_result_i),
		.store_data_i  (store_data_i),
		.rd_i          (rd_i),
		.load_type_i   (load_type_i),
		.store_type_i  (store_type_i),
		.reg_we_o      (reg_we_o),
		.reg_waddr_o   (reg_waddr_o),
		.reg_wdata_o   (reg_wdata_o),
		.busy_o        (busy_o),
		.data_req_o    (data_req),
		.data_addr_o   (data_addr),
		.data_we_o     (data_we),
		.data_be_o     (data_be),
		.data_wdata_o  (data_wdata),
		.data_gnt_i    (data_gnt),
		.data_rvalid_i (data_rvalid),
		.data_rdata_i  (data_rdata)
	);

	// Wait states set the load latency
	data_ram #(
		.WAIT_STATES (WAIT_STATES)
	) u_data_ram (
		.clk           (clk),
		.rst_i         (rst_i),
		.data_req_i    (data_req),
		.data_addr_i   (data_addr),
		.data_we_i     (data_we),
		.data_be_i     (data_be),
		.data_wdata_i  (data_wdata),
		.data_gnt_o    (data_gnt),
		.data_rvalid_o (data_rvalid),
		.data_rdata_o  (data_rdata)
	);

endmodule

// ==== verification/wb_checker.sv ====
`timescale 1ns/100ps

module wb_checker #(
	parameter int MAX_WAIT    = 50,
	parameter int WAIT_STATES = 2
) (
	input  logic                                     clk_i,
	input  logic                                     rst_i,

	// Execute side as driven into the DUT
	input  logic                                     valid_i,
	input  logic [riscv_defines::WORD_WIDTH-1:0]     alu_result_i,
	input  logic [riscv_defines::WORD_WIDTH-1:0]     store_data_i,
	input  logic [riscv_defines::REG_ADDR_WIDTH-1:0] rd_i,
	input  logic [2:0]                               load_type_i,
	input  logic [1:0]                               store_type_i,

	// Expected value from the table overrides the model
	input  logic                                     exp_en_i,
	input  logic [riscv_defines::WORD_WIDTH-1:0]     exp_data_i,

	// DUT outputs
	input  logic                                     reg_we_i,
	input  logic [riscv_defines::REG_ADDR_WIDTH-1:0] reg_waddr_i,
	input  logic [riscv_defines::WORD_WIDTH-1:0]     reg_wdata_i,
	input  logic                                     busy_i,

	output int                                       pass_cnt_o,
	output int                                       fail_cnt_o
);

	import riscv_defines::*;

	typedef enum logic [1:0] {OP_NONE, OP_ALU, OP_LOAD, OP_STORE} op_kind_e;

	// Byte-addressed model of the 256-word RAM
	logic [7:0]                mem_model [0:1023] = '{default: 8'h00};

	// Instruction in flight
	op_kind_e                  kind_q;
	logic [WORD_WIDTH-1:0]     exp_q;
	logic [REG_ADDR_WIDTH-1:0] rd_q;
	int                        age_q;
	int                        test_no;
	string                     desc_q;
	logic                      bad_q;
	string                     why_q;

	function automatic string op_name(input logic [2:0] lt, input logic [1:0] st);
		case (lt)
			LOAD_LB:  return "LB";
			LOAD_LBU: return "LBU";
			LOAD_LH:  return "LH";
			LOAD_LHU: return "LHU";
			LOAD_LW:  return "LW";
			default:  ;
		endcase
		case (st)
			STORE_SB: return "SB";
			STORE_SH: return "SH";
			STORE_SW: return "SW";
			default:  return "ALU";
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Memory model
	////////////////////////////////////////////////////////////////////////////

	// Low address bits below the access size are ignored
	function automatic logic [31:0] predict_load(input logic [2:0] lt, input logic [31:0] a);
		logic [7:0]  b;
		logic [15:0] h;
		logic [31:0] w;
		b = mem_model[a[9:0]];
		h = {mem_model[{a[9:1], 1'b1}], mem_model[{a[9:1], 1'b0}]};
		w = {mem_model[{a[9:2], 2'd3}], mem_model[{a[9:2], 2'd2}],
			mem_model[{a[9:2], 2'd1}], mem_model[{a[9:2], 2'd0}]};
		case (lt)
			LOAD_LB:  return {{24{b[7]}}, b};
			LOAD_LBU: return {24'h0, b};
			LOAD_LH:  return {{16{h[15]}}, h};
			LOAD_LHU: return {16'h0, h};
			default:  return w;
		endcase
	endfunction

	task automatic apply_store(input logic [1:0] st, input logic [31:0] a, input logic [31:0] d);
		case (st)
			STORE_SB: mem_model[a[9:0]] = d[7:0];
			STORE_SH: begin
				mem_model[{a[9:1], 1'b0}] = d[7:0];
				mem_model[{a[9:1], 1'b1}] = d[15:8];
			end
			default: begin
				mem_model[{a[9:2], 2'd0}] = d[7:0];
				mem_model[{a[9:2], 2'd1}] = d[15:8];
				mem_model[{a[9:2], 2'd2}] = d[23:16];
				mem_model[{a[9:2], 2'd3}] = d[31:24];
			end
		endcase
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Per-test verdicts
	////////////////////////////////////////////////////////////////////////////

	// One line per finished test
	task automatic finish_write();
		if (reg_waddr_i !== rd_q) begin
			$display("ERROR t=%0t reg_waddr_o expected %0d actual %0d (test %0d %s)",
				$time, rd_q, reg_waddr_i, test_no, desc_q);
			fail_cnt_o++;
		end else if (reg_wdata_i !== exp_q) begin
			$display("ERROR t=%0t reg_wdata_o expected %h actual %h (test %0d %s)",
				$time, exp_q, reg_wdata_i, test_no, desc_q);
			fail_cnt_o++;
		end else if (bad_q) begin
			$display("Test %0d %s failed, %s", test_no, desc_q, why_q);
			fail_cnt_o++;
		end else begin
			$display("PASS test %0d %s", test_no, desc_q);
			pass_cnt_o++;
		end
	endtask

	task automatic finish_store();
		if (bad_q) begin
			$display("Test %0d %s failed, %s", test_no, desc_q, why_q);
			fail_cnt_o++;
		end else begin
			$display("PASS test %0d %s", test_no, desc_q);
			pass_cnt_o++;
		end
	endtask

	always @(posedge clk_i) begin
		if (rst_i) begin
			kind_q     = OP_NONE;
			age_q      = 0;
			test_no    = 0;
			pass_cnt_o = 0;
			fail_cnt_o = 0;
		end else begin
			// Register write port
			if (reg_we_i) begin
				if (kind_q == OP_ALU || kind_q == OP_LOAD) begin
					finish_write();
					kind_q = OP_NONE;
				end else if (kind_q == OP_STORE) begin
					bad_q = 1'b1;
					why_q = "register write during a store";
				end else begin
					$display("Register write to x%0d at %0t with no instruction pending",
						reg_waddr_i, $time);
					fail_cnt_o++;
				end
			end else if (kind_q == OP_ALU) begin
				$display("Test %0d %s failed, no register write one cycle after valid",
					test_no, desc_q);
				fail_cnt_o++;
				kind_q = OP_NONE;
			end else if (kind_q != OP_NONE && age_q >= MAX_WAIT) begin
				$display("Test %0d %s failed, not finished within %0d cycles",
					test_no, desc_q, MAX_WAIT);
				fail_cnt_o++;
				kind_q = OP_NONE;
			end

			// Stall level across the memory transaction
			// A store keeps busy_o through the grant wait and the grant cycle
			if (kind_q == OP_LOAD && !busy_i) begin
				bad_q = 1'b1;
				why_q = "busy_o low before the load write";
			end else if (kind_q == OP_STORE && !busy_i) begin
				if (age_q != WAIT_STATES + 1) begin
					bad_q = 1'b1;
					why_q = $sformatf("busy_o high for %0d cycles instead of %0d",
						age_q, WAIT_STATES + 1);
				end
				finish_store();
				kind_q = OP_NONE;
			end

			if (kind_q != OP_NONE) begin
				age_q++;
			end

			// Capture a new instruction
			if (valid_i) begin
				if (kind_q != OP_NONE) begin
					$display("Test %0d issued while test %0d was still pending",
						test_no + 1, test_no);
					fail_cnt_o++;
				end
				test_no++;
				rd_q   = rd_i;
				age_q  = 0;
				bad_q  = 1'b0;
				desc_q = $sformatf("%s %h", op_name(load_type_i, store_type_i), alu_result_i);
				if (load_type_i != LOAD_NONE) begin
					kind_q = OP_LOAD;
					exp_q  = exp_en_i ? exp_data_i : predict_load(load_type_i, alu_result_i);
				end else if (store_type_i != STORE_NONE) begin
					kind_q = OP_STORE;
					apply_store(store_type_i, alu_result_i, store_data_i);
				end else begin
					kind_q = OP_ALU;
					exp_q  = exp_en_i ? exp_data_i : alu_result_i;
				end
			end
		end
	end

endmodule

// ==== verification/tb_wb_subsystem.sv ====
`timescale 1ns/100ps

module tb_wb_subsystem #(
	parameter int MAX_WAIT    = 50,
	parameter int WAIT_STATES = 2
);

	import riscv_defines::*;

	// One row of the stimulus table
	typedef struct packed {
		logic [2:0]  load_type;
		logic [1:0]  store_type;
		logic [31:0] addr;
		logic [31:0] data;
		logic [4:0]  rd;
		logic [31:0] exp;
		logic        has_exp;
	} entry_t;

	logic        clk = 1'b0;
	logic        rst_i;
	logic        valid_i;
	logic [31:0] alu_result_i;
	logic [31:0] store_data_i;
	logic [4:0]  rd_i;
	logic [2:0]  load_type_i;
	logic [1:0]  store_type_i;
	logic        exp_en;
	logic [31:0] exp_data;
	logic        reg_we_o;
	logic [4:0]  reg_waddr_o;
	logic [31:0] reg_wdata_o;
	logic        busy_o;
	int          pass_cnt;
	int          fail_cnt;

	entry_t      table_q [$];
	logic [31:0] seed;
	logic        timed_out;
	int          idx;

	// 8 ns period
	always #4 clk = ~clk;

	wb_subsystem #(
		.WAIT_STATES (WAIT_STATES)
	) dut0 (
		.clk          (clk),
		.rst_i        (rst_i),
		.valid_i      (valid_i),
		.alu_result_i (alu_result_i),
		.store_data_i (store_data_i),
		.rd_i         (rd_i),
		.load_type_i  (load_type_i),
		.store_type_i (store_type_i),
		.reg_we_o     (reg_we_o),
		.reg_waddr_o  (reg_waddr_o),
		.reg_wdata_o  (reg_wdata_o),
		.busy_o       (busy_o)
	);

	wb_checker #(
		.MAX_WAIT    (MAX_WAIT),
		.WAIT_STATES (WAIT_STATES)
	) chk0 (
		.clk_i        (clk),
		.rst_i        (rst_i),
		.valid_i      (valid_i),
		.alu_result_i (alu_result_i),
		.store_data_i (store_data_i),
		.rd_i         (rd_i),
		.load_type_i  (load_type_i),
		.store_type_i (store_type_i),
		.exp_en_i     (exp_en),
		.exp_data_i   (exp_data),
		.reg_we_i     (reg_we_o),
		.reg_waddr_i  (reg_waddr_o),
		.reg_wdata_i  (reg_wdata_o),
		.busy_i       (busy_o),
		.pass_cnt_o   (pass_cnt),
		.fail_cnt_o   (fail_cnt)
	);

	////////////////////////////////////////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] next_rand(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic add_entry(input logic [2:0] lt, input logic [1:0] st, input logic [31:0] a,
		input logic [31:0] d, input logic [4:0] r, input logic [31:0] e, input logic he);
		entry_t ent;
		ent = {lt, st, a, d, r, e, he};
		table_q.push_back(ent);
	endtask

	// Mixed stores and loads over 16 words at 0x200
	task automatic add_random_entries(input int count);
		logic [31:0] r;
		logic [2:0]  lt;
		logic [1:0]  st;
		for (int i = 0; i < count; i++) begin
			seed = next_rand(seed);
			r    = seed;
			lt   = LOAD_NONE;
			st   = STORE_NONE;
			if (r[31]) begin
				case (r[30:28])
					3'd0, 3'd5: lt = LOAD_LB;
					3'd1, 3'd6: lt = LOAD_LBU;
					3'd2, 3'd7: lt = LOAD_LH;
					3'd3:       lt = LOAD_LHU;
					default:    lt = LOAD_LW;
				endcase
			end else begin
				case (r[27:26])
					2'd0:    st = STORE_SB;
					2'd1:    st = STORE_SH;
					default: st = STORE_SW;
				endcase
			end
			seed = next_rand(seed);
			add_entry(lt, st, 32'h0000_0200 | {26'h0, r[5:0]}, seed, r[20:16], 32'h0, 1'b0);
		end
	endtask

	task automatic fill_table();
		// ALU writeback
		add_entry(LOAD_NONE, STORE_NONE, 32'h1234_5678, 32'h0, 5'd1, 32'h1234_5678, 1'b1);
		add_entry(LOAD_NONE, STORE_NONE, 32'hfedc_ba98, 32'h0, 5'd31, 32'hfedc_ba98, 1'b1);
		// Word round trip
		add_entry(LOAD_NONE, STORE_SW, 32'h0000_0100, 32'hdead_beef, 5'd0, 32'h0, 1'b0);
		add_entry(LOAD_LW, STORE_NONE, 32'h0000_0100, 32'h0, 5'd2, 32'hdead_beef, 1'b1);
		// Byte lanes 0 to 3 with junk in the upper store bits
		// A word load after each byte store shows the lanes left alone
		add_entry(LOAD_NONE, STORE_SW, 32'h0000_0104, 32'h1122_3344, 5'd0, 32'h0, 1'b0);
		add_entry(LOAD_NONE, STORE_SB, 32'h0000_0104, 32'hffff_ffa0, 5'd0, 32'h0, 1'b0);
		add_entry(LOAD_LW, STORE_NONE, 32'h0000_0104, 32'h0, 5'd15, 32'h1122_33a0, 1'b1);
		add_entry(LOAD_NONE, STORE_SB, 32'h0000_0105, 32'h1234_56b1, 5'd0, 32'h0, 1'b0);
		add_entry(LOAD_LW, STORE_NONE, 32'h0000_0104, 32'h0, 5'd16, 32'h1122_b1a0, 1'b1);
		add_entry(LOAD_NONE, STORE_SB, 32'h0000_0106, 32'h0000_00c2, 5'd0, 32'h0, 1'b0);
		add_entry(LOAD_LW, STORE_NONE, 32'h0000_0104, 32'h0, 5'd17, 32'h11c2_b1a0, 1'b1);
		add_entry(LOAD_NONE, STORE_SB, 32'h0000_0107, 32'heeee_eed3, 5'd0, 32'h0, 1'b0);
		add_entry(LOAD_LW, STORE_NONE, 32'h0000_0104, 32'h0, 5'd3, 32'hd3c2_b1a0, 1'b1);
		// Halfword lanes
		add_entry(LOAD_NONE, STORE_SH, 32'h0000_0104, 32'habcd_5566, 5'd0, 32'h0, 1'b0);
		add_entry(LOAD_LW, STORE_NONE, 32'h0000_0104, 32'h0, 5'd18, 32'hd3c2_5566, 1'b1);
		add_entry(LOAD_NONE, STORE_SH, 32'h0000_0106, 32'h0000_7788, 5'd0, 32'h0, 1'b0);
		add_entry(LOAD_LW, STORE_NONE, 32'h0000_0104, 32'h0, 5'd4, 32'h7788_5566, 1'b1);
		// Sign and zero extension with the sign bit set and clear
		add_entry(LOAD_NONE, STORE_SW, 32'h0000_0108, 32'h80f4_7f12, 5'd0, 32'h0, 1'b0);
		add_entry(LOAD_LB, STORE_NONE, 32'h0000_010b, 32'h0, 5'd5, 32'hffff_ff80, 1'b1);
		add_entry(LOAD_LBU, STORE_NONE, 32'h0000_010b, 32'h0, 5'd6, 32'h0000_0080, 1'b1);
		add_entry(LOAD_LB, STORE_NONE, 32'h0000_0109, 32'h0, 5'd7, 32'h0000_007f, 1'b1);
		add_entry(LOAD_LBU, STORE_NONE, 32'h0000_0109, 32'h0, 5'd8, 32'h0000_007f, 1'b1);
		add_entry(LOAD_LB, STORE_NONE, 32'h0000_010a, 32'h0, 5'd9, 32'hffff_fff4, 1'b1);
		add_entry(LOAD_LBU, STORE_NONE, 32'h0000_010a, 32'h0, 5'd10, 32'h0000_00f4, 1'b1);
		add_entry(LOAD_LH, STORE_NONE, 32'h0000_010a, 32'h0, 5'd11, 32'hffff_80f4, 1'b1);
		add_entry(LOAD_LHU, STORE_NONE, 32'h0000_010a, 32'h0, 5'd12, 32'h0000_80f4, 1'b1);
		add_entry(LOAD_LH, STORE_NONE, 32'h0000_0108, 32'h0, 5'd13, 32'h0000_7f12, 1'b1);
		add_entry(LOAD_LHU, STORE_NONE, 32'h0000_0108, 32'h0, 5'd14, 32'h0000_7f12, 1'b1);
		add_random_entries(16);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Driving and waiting
	////////////////////////////////////////////////////////////////////////////

	// One-cycle valid pulse on the rising edge
	task automatic apply_entry(input entry_t ent);
		@(posedge clk);
		valid_i      <= 1'b1;
		alu_result_i <= ent.addr;
		store_data_i <= ent.data;
		rd_i         <= ent.rd;
		load_type_i  <= ent.load_type;
		store_type_i <= ent.store_type;
		exp_en       <= ent.has_exp;
		exp_data     <= ent.exp;
		@(posedge clk);
		valid_i      <= 1'b0;
		load_type_i  <= LOAD_NONE;
		store_type_i <= STORE_NONE;
		exp_en       <= 1'b0;
	endtask

	// busy_o is looked at on the falling edge
	task automatic wait_idle(output logic late);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (busy_o && cycles < MAX_WAIT) begin
			@(negedge clk);
			cycles++;
		end
		late = busy_o;
	endtask

	initial begin
		rst_i        = 1'b1;
		valid_i      = 1'b0;
		alu_result_i = 32'h0;
		store_data_i = 32'h0;
		rd_i         = 5'd0;
		load_type_i  = LOAD_NONE;
		store_type_i = STORE_NONE;
		exp_en       = 1'b0;
		exp_data     = 32'h0;
		seed         = 32'h8791a060;
		timed_out    = 1'b0;
		fill_table();
		repeat (5) @(posedge clk);
		rst_i <= 1'b0;

		idx = 0;
		while (idx < table_q.size() && !timed_out) begin
			apply_entry(table_q[idx]);
			wait_idle(timed_out);
			idx++;
		end
		// Last register write still has to reach the checker
		repeat (3) @(posedge clk);

		if (timed_out) begin
			$display("busy_o stayed high for more than %0d cycles in entry %0d", MAX_WAIT, idx - 1);
		end else if (pass_cnt + fail_cnt != table_q.size()) begin
			$display("Checker finished %0d of %0d tests", pass_cnt + fail_cnt, table_q.size());
		end
		$display("Tests passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (!timed_out && fail_cnt == 0 && pass_cnt == table_q.size()) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== wb_subsystem.f ====
rtl/riscv_defines.sv
rtl/lsu_lite.sv
rtl/wb_stage.sv
rtl/data_ram.sv
rtl/wb_subsystem.sv
verification/wb_checker.sv
verification/tb_wb_subsystem.sv

// ==== Makefile ====
# Verilator build and run of the writeback subsystem testbench
# Any variable can be overridden on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_wb_subsystem
FILELIST  ?= wb_subsystem.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

# Sources are the non-option lines of the file list
SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail is decided by the log, not by the exit status of the binary
run: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	@grep -q '^TEST OK$$' $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
